// File: cart_macros.svh
// Widths, address prefixes, header offset and key codes for the cart loader; include in the RTL
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

////////////////////////////////
// Bus widths
////////////////////////////////
`define CART_DL_ADDR_W   25
`define CART_DATA_W      16
`define CART_MEM_ADDR_W  25

// Page register bank
`define CART_BANK_W      5
`define CART_BANK_COUNT  8

// ROM mask covers address bits 23..13
`define CART_MASK_W      11

////////////////////////////////
// Download header
////////////////////////////////
`define CART_HDR_REGION_ADDR  25'h1F0

// Keyboard codes in the low nine bits of the key event
`define CART_KEY_F1  9'h005
`define CART_KEY_F2  9'h006
`define CART_KEY_F3  9'h004

////////////////////////////////
// SDRAM word address prefixes
////////////////////////////////
`define CART_PFX_WRAM       10'b0010000000  // 800000-80FFFF
`define CART_PFX_CRAM       6'b001110       // E00000-EFFFFF
`define CART_PFX_BIOS       9'b001111000    // F00000-F1FFFF
`define CART_PFX_LOAD_BIOS  7'b0011110      // F00000-F7FFFF while loading

`endif

// File: cart_pkg.sv
// Shared types of the cart loader; modules pull them in by import
package cart_pkg;

	// Console region, encoded as the host status field expects
	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_e;

	// Which memory the CPU access lands in
	typedef enum logic [1:0] {
		tgt_wram = 2'd0,  // Work RAM
		tgt_cram = 2'd1,  // Cart backup RAM
		tgt_crom = 2'd2,  // Banked cart ROM
		tgt_bios = 2'd3   // Default when nothing else is selected
	} mem_target_e;

endpackage

// File: cart_info_if.sv
// Parsed download information, driven by the header parser and read by region select and memory map
`timescale 1ns/1ps
`include "cart_macros.svh"

interface cart_info_if;
	import cart_pkg::*;

	logic                    rom_loading;  // ROM image download in progress
	logic                    cart_mode;
	logic [`CART_MASK_W-1:0] rom_mask;     // Address bits 23..13 seen in the image
	logic                    hdr_ready;
	region_e                 hdr_region;

	modport src (
		output rom_loading, cart_mode, rom_mask, hdr_ready, hdr_region
	);

	modport region (
		input hdr_ready, hdr_region
	);

	modport map (
		input rom_loading, cart_mode, rom_mask
	);

endinterface

// File: cart_header_parser.sv
// Watches the download stream and derives loading flag, cart mode, ROM mask and header region
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_header_parser (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_active,
	input  logic [7:0]                 dl_index,
	input  logic                       dl_wr,
	input  logic [`CART_DL_ADDR_W-1:0] dl_addr,
	input  logic [`CART_DATA_W-1:0]    dl_data,
	cart_info_if.src                   info
);
	import cart_pkg::*;

	logic                    loading;
	logic                    loading_d;
	logic                    load_wr;
	logic                    hdr_wr;
	logic                    u_now;
	logic                    j_now;
	logic                    seen_u;
	logic                    seen_j;
	logic                    cart_mode_q;
	logic [`CART_MASK_W-1:0] rom_mask_q;
	logic                    hdr_ready_q;
	region_e                 hdr_region_q;

	// ROM images use index 0 or 1 in the low six bits
	assign loading = dl_active & (dl_index[5:0] <= 6'h01);
	assign load_wr = loading & dl_wr;
	assign hdr_wr  = load_wr & (dl_addr == `CART_HDR_REGION_ADDR);

	// Region letters seen so far, this write included
	assign u_now = seen_u | (dl_data[7:0] == "U");
	assign j_now = seen_j | (dl_data[7:0] == "J");

	//////////////////////////////
	// Mode and size
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mode_q <= 1'b0;
			rom_mask_q  <= '0;
		end else if (load_wr) begin
			cart_mode_q <= dl_index[6];
			if (dl_addr == '0) begin
				rom_mask_q <= '0;  // Fresh image
			end else begin
				rom_mask_q <= rom_mask_q | dl_addr[23:13];
			end
		end
	end

	//////////////////////////////
	// Header region
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loading_d    <= 1'b0;
			seen_u       <= 1'b0;
			seen_j       <= 1'b0;
			hdr_ready_q  <= 1'b0;
			hdr_region_q <= region_jp;
		end else begin
			loading_d <= loading;

			if (loading & ~loading_d) begin  // Download starts
				seen_u       <= 1'b0;
				seen_j       <= 1'b0;
				hdr_ready_q  <= 1'b0;
				hdr_region_q <= region_jp;
			end

			if (~loading & loading_d) hdr_ready_q <= 1'b0;

			if (hdr_wr) begin
				seen_u      <= u_now;
				seen_j      <= j_now;
				hdr_ready_q <= 1'b1;
				// US beats JP, anything else is EU
				if (u_now) hdr_region_q <= region_us;
				else if (j_now) hdr_region_q <= region_jp;
				else hdr_region_q <= region_eu;
			end
		end
	end

	assign info.rom_loading = loading;
	assign info.cart_mode   = cart_mode_q;
	assign info.rom_mask    = rom_mask_q;
	assign info.hdr_ready   = hdr_ready_q;
	assign info.hdr_region  = hdr_region_q;

endmodule

// File: region_select.sv
// Picks the console region from keyboard F-keys or the cart header and pulses the host set flag
`timescale 1ns/1ps
`include "cart_macros.svh"

module region_select (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [10:0]       key_event,
	cart_info_if.region       info,
	output cart_pkg::region_e region_req,
	output logic              region_set
);
	import cart_pkg::*;

	logic       key_stb_d;
	logic       key_toggle;
	logic       key_pressed;
	logic [8:0] key_code;
	logic       ready_d;
	logic       ready_rise;
	logic       ready_fall;

	assign key_toggle  = key_stb_d ^ key_event[10];  // Every new key event flips bit 10
	assign key_pressed = key_event[9];
	assign key_code    = key_event[8:0];

	assign ready_rise = ~ready_d & info.hdr_ready;
	assign ready_fall = ready_d & ~info.hdr_ready;

	//////////////////////////////
	// Edge history
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_stb_d <= key_event[10];  // No false toggle out of reset
			ready_d   <= 1'b0;
		end else begin
			key_stb_d <= key_event[10];
			ready_d   <= info.hdr_ready;
		end
	end

	//////////////////////////////
	// Region request
	//////////////////////////////
	// The header is applied after the keys, so it wins a same-cycle clash
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= region_jp;
			region_set <= 1'b0;
		end else begin
			if (key_toggle) begin
				case (key_code)
					`CART_KEY_F1: begin
						region_req <= region_jp;
						region_set <= key_pressed;
					end
					`CART_KEY_F2: begin
						region_req <= region_us;
						region_set <= key_pressed;
					end
					`CART_KEY_F3: begin
						region_req <= region_eu;
						region_set <= key_pressed;
					end
					default: ;  // Other keys ignored
				endcase
			end

			if (ready_rise) begin
				region_req <= info.hdr_region;
				region_set <= 1'b1;
			end

			if (ready_fall) region_set <= 1'b0;  // Download finished
		end
	end

endmodule

// File: cart_mem_map.sv
// Page register bank mapper and SDRAM word address decode for CPU accesses and image loading
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_mem_map (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [23:1]                 bus_addr,
	input  logic [`CART_DATA_W-1:0]     bus_data,
	input  logic                        bus_rnw,
	input  logic                        page_cs_n,
	input  logic                        wram_cs_n,
	input  logic                        cram_cs_n,
	input  logic                        crom_cs_n,
	input  logic [`CART_DL_ADDR_W-1:0]  dl_addr,
	cart_info_if.map                    info,
	output logic [`CART_MEM_ADDR_W-1:0] mem_addr
);
	import cart_pkg::*;

	logic [`CART_BANK_W-1:0] bank_reg [`CART_BANK_COUNT];
	logic                    page_cs_d;
	logic                    page_edge;
	logic                    big_image;
	logic                    page_wr;
	logic [2:0]              page_sel;
	logic [`CART_BANK_W-1:0] win_bank;
	logic [23:1]             rom_va;
	mem_target_e             target;

	assign page_sel  = bus_addr[3:1];
	assign page_edge = page_cs_d & ~page_cs_n;  // First low cycle of the select

	// Mapper only answers above 4 MB
	assign big_image = info.rom_mask[10] | info.rom_mask[9];

	// Register 0 is fixed to bank 0
	assign page_wr = page_edge & big_image & ~bus_rnw & (page_sel != 3'd0);

	//////////////////////////////
	// Bank registers
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_cs_d <= 1'b1;
		end else begin
			page_cs_d <= page_cs_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset | info.rom_loading) begin
			// Identity mapping, window n shows bank n
			for (int i = 0; i < `CART_BANK_COUNT; i++) begin
				bank_reg[i] <= `CART_BANK_W'(i);
			end
		end else if (page_wr) begin
			bank_reg[page_sel] <= bus_data[`CART_BANK_W-1:0];
		end
	end

	//////////////////////////////
	// ROM address
	//////////////////////////////
	// 512 KB windows picked by bus_addr[21:19]
	assign win_bank = bank_reg[bus_addr[21:19]];

	// Mirror smaller images by masking off unused high bits
	assign rom_va = {win_bank, bus_addr[18:1]} & {info.rom_mask, 12'hFFF};

	always_comb begin
		if (!wram_cs_n) begin
			target = tgt_wram;
		end else if (!cram_cs_n) begin
			target = tgt_cram;
		end else if (!crom_cs_n) begin
			target = tgt_crom;
		end else begin
			target = tgt_bios;
		end
	end

	//////////////////////////////
	// SDRAM word address
	//////////////////////////////
	always_comb begin
		if (info.rom_loading) begin
			if (info.cart_mode) begin
				mem_addr = {3'b000, dl_addr[22:1]};  // Cart image at 000000
			end else begin
				mem_addr = {`CART_PFX_LOAD_BIOS, dl_addr[18:1]};
			end
		end else begin
			case (target)
				tgt_wram: mem_addr = {`CART_PFX_WRAM, bus_addr[15:1]};
				tgt_cram: mem_addr = {`CART_PFX_CRAM, bus_addr[19:1]};
				tgt_crom: mem_addr = {3'b000, rom_va[22:1]};
				default:  mem_addr = {`CART_PFX_BIOS, bus_addr[16:1]};
			endcase
		end
	end

endmodule

// File: cart_loader_top.sv
// Top level of the cart loader: header parser, region select and memory map on plain ports
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_loader_top (
	input  logic                        clk_sys,
	input  logic                        reset,

	// Download stream
	input  logic                        dl_active,
	input  logic [7:0]                  dl_index,
	input  logic                        dl_wr,
	input  logic [`CART_DL_ADDR_W-1:0]  dl_addr,
	input  logic [`CART_DATA_W-1:0]     dl_data,

	// Keyboard
	input  logic [10:0]                 key_event,

	// CPU side
	input  logic [23:1]                 bus_addr,
	input  logic [`CART_DATA_W-1:0]     bus_data,
	input  logic                        bus_rnw,
	input  logic                        page_cs_n,
	input  logic                        wram_cs_n,
	input  logic                        cram_cs_n,
	input  logic                        crom_cs_n,

	output logic [1:0]                  region_req,
	output logic                        region_set,
	output logic [`CART_MEM_ADDR_W-1:0] mem_addr
);
	import cart_pkg::*;

	region_e region_q;

	cart_info_if info_bus ();

	cart_header_parser u_parser (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.info      (info_bus)
	);

	region_select u_region (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.key_event  (key_event),
		.info       (info_bus),
		.region_req (region_q),
		.region_set (region_set)
	);

	cart_mem_map u_map (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus_addr  (bus_addr),
		.bus_data  (bus_data),
		.bus_rnw   (bus_rnw),
		.page_cs_n (page_cs_n),
		.wram_cs_n (wram_cs_n),
		.cram_cs_n (cram_cs_n),
		.crom_cs_n (crom_cs_n),
		.dl_addr   (dl_addr),
		.info      (info_bus),
		.mem_addr  (mem_addr)
	);

	assign region_req = region_q;  // Raw code for the host status field

endmodule

// File: tb_cart_loader.sv
// Testbench for the cart loader top level that applies a table of stimulus rows and checks each one
`timescale 1ns/1ps

module tb_cart_loader;

	typedef enum logic [2:0] {
		op_idle,   // Download stream quiet
		op_dl_wr,  // One download write
		op_key,    // New key event word
		op_page,   // Page register write
		op_bus     // CPU access with chip selects
	} op_e;

	typedef struct packed {
		int          test;
		op_e         op;
		logic [7:0]  idx;
		logic [24:0] addr;      // dl_addr or CPU byte address
		logic [15:0] data;      // dl_data, bus_data or key_event
		logic [2:0]  cs;        // {wram_cs_n, cram_cs_n, crom_cs_n}
		int          lat;       // Clocks until the check
		logic [1:0]  chk;       // {region, mem_addr}
		logic [1:0]  exp_req;
		logic        exp_set;
		logic [24:0] exp_addr;
	} row_t;

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [10:0] key_event;
	logic [23:1] bus_addr;
	logic [15:0] bus_data;
	logic        bus_rnw;
	logic        page_cs_n;
	logic        wram_cs_n;
	logic        cram_cs_n;
	logic        crom_cs_n;
	logic [1:0]  region_req;
	logic        region_set;
	logic [24:0] mem_addr;

	row_t rows [$];
	logic table_ready = 1'b0;
	int   cur_row;
	int   errors = 0;
	int   checks = 0;
	int   test_errors = 0;
	int   test_checks = 0;

	cart_loader_top UUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.key_event  (key_event),
		.bus_addr   (bus_addr),
		.bus_data   (bus_data),
		.bus_rnw    (bus_rnw),
		.page_cs_n  (page_cs_n),
		.wram_cs_n  (wram_cs_n),
		.cram_cs_n  (cram_cs_n),
		.crom_cs_n  (crom_cs_n),
		.region_req (region_req),
		.region_set (region_set),
		.mem_addr   (mem_addr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// Table helpers
	//////////////////////////////
	task automatic add_row(input int test, input op_e op, input logic [7:0] idx,
			input logic [24:0] addr, input logic [15:0] data, input logic [2:0] cs,
			input int lat, input logic [1:0] chk, input logic [1:0] exp_req,
			input logic exp_set, input logic [24:0] exp_addr);
		row_t r;
		r.test     = test;
		r.op       = op;
		r.idx      = idx;
		r.addr     = addr;
		r.data     = data;
		r.cs       = cs;
		r.lat      = lat;
		r.chk      = chk;
		r.exp_req  = exp_req;
		r.exp_set  = exp_set;
		r.exp_addr = exp_addr;
		rows.push_back(r);
	endtask

	function automatic string test_name(input int test);
		case (test)
			1:       return "reset and BIOS decode";
			2:       return "header region";
			3:       return "keyboard region";
			4:       return "load address";
			5:       return "page mapper";
			default: return "cart RAM";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		test_checks++;
		if (got !== want) begin
			errors++;
			test_errors++;
			$display("Error: %s expected 0x%0h, got 0x%0h in row %0d", name, want, got, cur_row);
		end
	endtask

	task automatic check_row(input row_t r);
		if (r.chk[1]) begin
			check_value("region_req", 32'(region_req), 32'(r.exp_req));
			check_value("region_set", 32'(region_set), 32'(r.exp_set));
		end
		if (r.chk[0]) check_value("mem_addr", 32'(mem_addr), 32'(r.exp_addr));
	endtask

	// Inputs change on the falling edge only
	task automatic apply_row(input row_t r);
		@(negedge clk_sys);
		case (r.op)
			op_idle: dl_active = 1'b0;
			op_dl_wr: begin
				dl_active = 1'b1;
				dl_index  = r.idx;
				dl_addr   = r.addr;
				dl_data   = r.data;
				dl_wr     = 1'b1;
			end
			op_key: key_event = r.data[10:0];
			op_page: begin
				bus_addr  = r.addr[23:1];
				bus_data  = r.data;
				bus_rnw   = 1'b0;
				{wram_cs_n, cram_cs_n, crom_cs_n} = 3'b111;
				page_cs_n = 1'b0;
			end
			default: begin
				bus_addr  = r.addr[23:1];
				bus_rnw   = 1'b1;
				page_cs_n = 1'b1;
				{wram_cs_n, cram_cs_n, crom_cs_n} = r.cs;
			end
		endcase
		if (r.lat == 0) begin
			#2;  // Decode is combinational
			check_row(r);
		end
		@(negedge clk_sys);
		dl_wr     = 1'b0;  // Strobes last one clock
		page_cs_n = 1'b1;
		bus_rnw   = 1'b1;
		if (r.lat != 0) begin
			repeat (r.lat - 1) @(negedge clk_sys);
			check_row(r);
		end
	endtask

	task automatic build_table();
		// Test 1
		add_row(1, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 1, 2'b10, 2'd0, 1'b0, 25'h0);
		add_row(1, op_bus, 8'h00, 25'h0012344, 16'h0000, 3'b111, 0, 2'b01, 2'd0, 1'b0, 25'h7891A2);
		add_row(1, op_bus, 8'h00, 25'h0FF1234, 16'h0000, 3'b010, 0, 2'b01, 2'd0, 1'b0, 25'h40091A);
		// Test 2 with a "U" header and then an "X" header
		add_row(2, op_dl_wr, 8'h40, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b10, 2'd0, 1'b0, 25'h0);
		add_row(2, op_dl_wr, 8'h40, 25'h0000100, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(2, op_dl_wr, 8'h40, 25'h00001F0, 16'h3A55, 3'b111, 2, 2'b10, 2'd1, 1'b1, 25'h0);
		add_row(2, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 2, 2'b10, 2'd1, 1'b0, 25'h0);
		add_row(2, op_dl_wr, 8'h40, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b10, 2'd1, 1'b0, 25'h0);
		add_row(2, op_dl_wr, 8'h40, 25'h00001F0, 16'h0058, 3'b111, 2, 2'b10, 2'd2, 1'b1, 25'h0);
		add_row(2, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 2, 2'b10, 2'd2, 1'b0, 25'h0);
		// Test 3 keys with toggle bit 10, pressed bit 9 and the code below
		add_row(3, op_key, 8'h00, 25'h0000000, 16'h0606, 3'b111, 1, 2'b10, 2'd1, 1'b1, 25'h0);
		add_row(3, op_key, 8'h00, 25'h0000000, 16'h0005, 3'b111, 1, 2'b10, 2'd0, 1'b0, 25'h0);
		add_row(3, op_key, 8'h00, 25'h0000000, 16'h0604, 3'b111, 1, 2'b10, 2'd2, 1'b1, 25'h0);
		add_row(3, op_key, 8'h00, 25'h0000000, 16'h021C, 3'b111, 1, 2'b10, 2'd2, 1'b1, 25'h0);
		// Test 4 loads in cart mode and then a BIOS image
		add_row(4, op_dl_wr, 8'h40, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(4, op_dl_wr, 8'h40, 25'h02468AC, 16'($urandom), 3'b111, 0, 2'b01, 2'd0, 1'b0,
			25'h123456);
		add_row(4, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(4, op_dl_wr, 8'h01, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(4, op_dl_wr, 8'h01, 25'h00ABCDE, 16'($urandom), 3'b111, 0, 2'b01, 2'd0, 1'b0,
			25'h795E6F);
		add_row(4, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		// Test 5 where a 2 MB image ignores the page write
		add_row(5, op_dl_wr, 8'h40, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_dl_wr, 8'h40, 25'h01FFFFE, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_page, 8'h00, 25'h0A130F6, 16'h001D, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_bus, 8'h00, 25'h0192468, 16'h0000, 3'b110, 0, 2'b01, 2'd0, 1'b0, 25'h0C9234);
		// 8 MB image takes bank 1Dh in window 3
		add_row(5, op_dl_wr, 8'h40, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_dl_wr, 8'h40, 25'h07FFFFE, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_page, 8'h00, 25'h0A130F6, 16'h001D, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_bus, 8'h00, 25'h0192468, 16'h0000, 3'b110, 0, 2'b01, 2'd0, 1'b0, 25'h349234);
		add_row(5, op_page, 8'h00, 25'h0A130F0, 16'h0007, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_bus, 8'h00, 25'h0012468, 16'h0000, 3'b110, 0, 2'b01, 2'd0, 1'b0, 25'h009234);
		// A fresh 2 MB image mirrors window 6 back into the first 2 MB
		add_row(5, op_dl_wr, 8'h40, 25'h0000000, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_dl_wr, 8'h40, 25'h01FFFFE, 16'($urandom), 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_idle, 8'h00, 25'h0000000, 16'h0000, 3'b111, 1, 2'b00, 2'd0, 1'b0, 25'h0);
		add_row(5, op_bus, 8'h00, 25'h0312468, 16'h0000, 3'b110, 0, 2'b01, 2'd0, 1'b0, 25'h089234);
		// Test 6 where cart RAM beats cart ROM
		add_row(6, op_bus, 8'h00, 25'h02ABCDE, 16'h0000, 3'b100, 0, 2'b01, 2'd0, 1'b0, 25'h755E6F);
	endtask

	task automatic report_test(input int test);
		$display("Test %0d %s: %0d checks, %0d errors", test, test_name(test), test_checks,
			test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int cur_test;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = 8'h00;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		key_event = '0;
		bus_addr  = '0;
		bus_data  = '0;
		bus_rnw   = 1'b1;
		page_cs_n = 1'b1;
		wram_cs_n = 1'b1;
		cram_cs_n = 1'b1;
		crom_cs_n = 1'b1;
		void'($urandom(13743));
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		cur_test = rows[0].test;
		for (int i = 0; i < rows.size(); i++) begin
			if (rows[i].test != cur_test) begin
				report_test(cur_test);
				cur_test = rows[i].test;
			end
			cur_row = i;
			apply_row(rows[i]);
		end
		report_test(cur_test);

		$display("Total: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Each row takes at most three clocks
	initial begin
		wait (table_ready);
		repeat (rows.size() * 20) @(posedge clk_sys);
		$display("Timeout: the stimulus table did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
cart_pkg.sv
cart_info_if.sv
cart_header_parser.sv
region_select.sv
cart_mem_map.sv
cart_loader_top.sv
tb_cart_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cart loader testbench with Verilator, runs it and scans the log for failure
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
	--top-module tb_cart_loader \
	-f src.f \
	-o sim_cart_loader

./obj_dir/sim_cart_loader | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failure"
